//--- Bender.yml
package:
  name: basics

sources:
  - basics_pkg.sv
  - cmd_frame_parser.sv
  - cmd_controller.sv
  - param_bank.sv
  - resp_fifo.sv
  - credit_tx.sv
  - basics_top.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_basics.sv

//--- basics_pkg.sv
package basics_pkg;

	// Widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  i2c_speed_t;
	typedef logic [15:0] i2c_addr_t;
	typedef logic [23:0] gpio_word_t;

	// Command bytes
	localparam byte_t CMD_VERSION    = 8'h76;
	localparam byte_t CMD_QUERY_I2C  = 8'h49;
	localparam byte_t CMD_SET_I2C    = 8'h69;
	localparam byte_t CMD_QUERY_GPIO = 8'h47;
	localparam byte_t CMD_SET_GPIO   = 8'h67;

	// Sub-command bytes
	localparam byte_t SUB_I2C_SPEED  = "c";
	localparam byte_t SUB_I2C_ADDR   = "a";
	localparam byte_t SUB_GPIO_LEVEL = "l";
	localparam byte_t SUB_GPIO_DIR   = "d";
	localparam byte_t SUB_GPIO_INT   = "i";

	// Response codes
	localparam byte_t RESP_ACK = 8'h00;
	localparam byte_t RESP_NAK = 8'h01;

	// Register values after reset
	localparam i2c_speed_t I2C_SPEED_RESET = 8'd99;
	localparam i2c_addr_t  I2C_ADDR_RESET  = 16'hFFFF;
	localparam gpio_word_t GPIO_RESET      = '0;

	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  frame;
	} in_bus_t;

	typedef struct packed {
		byte_t cmd;
		byte_t eid;
		logic  nak;
	} cmd_event_t;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_I2C_SPEED,
		SEL_I2C_ADDR,
		SEL_GPIO_LEVEL,
		SEL_GPIO_DIR,
		SEL_GPIO_INT
	} param_sel_t;

	typedef struct packed {
		param_sel_t sel;
		byte_t      data;
		logic       shift;
		logic       commit;
	} param_wr_t;

	typedef struct packed {
		byte_t data;
		logic  last;
	} resp_byte_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_VER,
		ST_QUERY_SUB,
		ST_SET_SUB,
		ST_SET_DATA,
		ST_HDR,
		ST_DATA,
		ST_DRAIN,
		ST_COMMIT
	} ctrl_state_t;

endpackage

//--- basics_top.sv
`timescale 1ns/10ps

module basics_top #(
	parameter basics_pkg::byte_t VERSION_MAJOR = 8'h00,
	parameter basics_pkg::byte_t VERSION_MINOR = 8'h03,
	parameter int                FIFO_DEPTH    = 16,
	parameter int                CREDIT_INIT   = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  basics_pkg::in_bus_t    in_bus,
	input  logic                   nak_request,
	input  logic                   credit_return,
	output basics_pkg::resp_byte_t out_byte,
	output logic                   out_valid,
	input  basics_pkg::gpio_word_t gpio_read,
	output basics_pkg::i2c_speed_t i2c_speed,
	output basics_pkg::i2c_addr_t  i2c_addr,
	output basics_pkg::gpio_word_t gpio_level,
	output basics_pkg::gpio_word_t gpio_direction,
	output basics_pkg::gpio_word_t gpio_int_enable
);
	import basics_pkg::*;

	cmd_event_t cmd_event;
	logic       cmd_event_valid;
	byte_t      pay_data;
	logic       pay_valid;
	param_wr_t  param_wr;
	gpio_word_t rd_value;
	logic       push;
	resp_byte_t push_data;
	logic       pop;
	resp_byte_t head;
	logic       empty;
	logic       full;
	logic       tx_busy;

	cmd_frame_parser i_parser (
		.clk             (clk),
		.rst             (rst),
		.in_bus          (in_bus),
		.nak_request     (nak_request),
		.cmd_event       (cmd_event),
		.cmd_event_valid (cmd_event_valid),
		.pay_data        (pay_data),
		.pay_valid       (pay_valid)
	);

	cmd_controller #(
		.VERSION_MAJOR (VERSION_MAJOR),
		.VERSION_MINOR (VERSION_MINOR)
	) i_controller (
		.clk             (clk),
		.rst             (rst),
		.cmd_event       (cmd_event),
		.cmd_event_valid (cmd_event_valid),
		.pay_data        (pay_data),
		.pay_valid       (pay_valid),
		.param_wr        (param_wr),
		.rd_value        (rd_value),
		.push            (push),
		.push_data       (push_data),
		.full            (full),
		.empty           (empty),
		.tx_busy         (tx_busy)
	);

	param_bank i_param_bank (
		.clk             (clk),
		.rst             (rst),
		.param_wr        (param_wr),
		.gpio_read       (gpio_read),
		.rd_value        (rd_value),
		.i2c_speed       (i2c_speed),
		.i2c_addr        (i2c_addr),
		.gpio_level      (gpio_level),
		.gpio_direction  (gpio_direction),
		.gpio_int_enable (gpio_int_enable)
	);

	resp_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_resp_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.full      (full)
	);

	credit_tx #(
		.CREDIT_INIT (CREDIT_INIT)
	) i_credit_tx (
		.clk           (clk),
		.rst           (rst),
		.head          (head),
		.empty         (empty),
		.pop           (pop),
		.credit_return (credit_return),
		.out_byte      (out_byte),
		.out_valid     (out_valid),
		.tx_busy       (tx_busy)
	);

endmodule

//--- cmd_controller.sv
`timescale 1ns/10ps

module cmd_controller #(
	parameter basics_pkg::byte_t VERSION_MAJOR = 8'h00,
	parameter basics_pkg::byte_t VERSION_MINOR = 8'h03
) (
	input  logic                     clk,
	input  logic                     rst,
	input  basics_pkg::cmd_event_t   cmd_event,
	input  logic                     cmd_event_valid,
	input  basics_pkg::byte_t        pay_data,
	input  logic                     pay_valid,
	output basics_pkg::param_wr_t    param_wr,
	input  basics_pkg::gpio_word_t   rd_value,
	output logic                     push,
	output basics_pkg::resp_byte_t   push_data,
	input  logic                     full,
	input  logic                     empty,
	input  logic                     tx_busy
);
	import basics_pkg::*;

	ctrl_state_t state;
	byte_t       cmd_q;
	byte_t       eid_q;
	byte_t       resp_code;
	byte_t       ver_byte;
	param_sel_t  sel_q;
	param_sel_t  sub_sel;
	logic [1:0]  cnt;
	logic [1:0]  hdr_idx;
	logic        after_data;
	logic        after_commit;
	logic        data_is_ver;
	byte_t       data_byte;

	// Map command and sub byte to a register or SEL_NONE
	function automatic param_sel_t decode_sub(input byte_t cmd, input byte_t sub);
		param_sel_t sel;
		sel = SEL_NONE;
		if (cmd == CMD_QUERY_I2C || cmd == CMD_SET_I2C) begin
			case (sub)
				SUB_I2C_SPEED: sel = SEL_I2C_SPEED;
				SUB_I2C_ADDR:  sel = SEL_I2C_ADDR;
				default:       sel = SEL_NONE;
			endcase
		end else if (cmd == CMD_QUERY_GPIO || cmd == CMD_SET_GPIO) begin
			case (sub)
				SUB_GPIO_LEVEL: sel = SEL_GPIO_LEVEL;
				SUB_GPIO_DIR:   sel = SEL_GPIO_DIR;
				SUB_GPIO_INT:   sel = SEL_GPIO_INT;
				default:        sel = SEL_NONE;
			endcase
		end
		return sel;
	endfunction

	// Register width in bytes
	function automatic logic [1:0] sel_width(input param_sel_t sel);
		case (sel)
			SEL_NONE:      return 2'd0;
			SEL_I2C_SPEED: return 2'd1;
			SEL_I2C_ADDR:  return 2'd2;
			default:       return 2'd3;
		endcase
	endfunction

	assign sub_sel = decode_sub(cmd_q, pay_data);

	always_comb begin
		if (data_is_ver) begin
			data_byte = (cnt == 2'd2) ? VERSION_MAJOR : VERSION_MINOR;
		end else begin
			case (cnt)
				2'd3:    data_byte = rd_value[23:16];
				2'd2:    data_byte = rd_value[15:8];
				default: data_byte = rd_value[7:0];
			endcase
		end
	end

	always_comb begin
		push      = 1'b0;
		push_data = '0;
		case (state)
			ST_HDR: begin
				push           = !full;
				push_data.last = (hdr_idx == 2'd2);
				case (hdr_idx)
					2'd0:    push_data.data = resp_code;
					2'd1:    push_data.data = eid_q;
					default: push_data.data = 8'h00;
				endcase
			end
			ST_DATA: begin
				push           = !full;
				push_data.data = data_byte;
				push_data.last = (cnt == 2'd1);
			end
			default: ;
		endcase
	end

	always_comb begin
		param_wr.sel    = sel_q;
		param_wr.data   = pay_data;
		param_wr.shift  = (state == ST_SET_DATA) && pay_valid;
		param_wr.commit = (state == ST_COMMIT);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= ST_IDLE;
			sel_q        <= SEL_NONE;
			resp_code    <= RESP_ACK;
			cnt          <= 2'd0;
			hdr_idx      <= 2'd0;
			after_data   <= 1'b0;
			after_commit <= 1'b0;
			data_is_ver  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_event_valid) begin
						sel_q        <= SEL_NONE;
						cnt          <= 2'd0;
						hdr_idx      <= 2'd0;
						after_data   <= 1'b0;
						after_commit <= 1'b0;
						data_is_ver  <= 1'b0;
						if (cmd_event.nak) begin
							resp_code <= RESP_NAK;
							state     <= ST_HDR;
						end else begin
							case (cmd_event.cmd)
								CMD_VERSION:                   state <= ST_VER;
								CMD_QUERY_I2C, CMD_QUERY_GPIO: state <= ST_QUERY_SUB;
								CMD_SET_I2C, CMD_SET_GPIO:     state <= ST_SET_SUB;
								default:                       state <= ST_IDLE;
							endcase
						end
					end
				end
				ST_VER: begin
					if (pay_valid) begin
						if (cnt == 2'd0) begin
							cnt <= 2'd1;
						end else begin
							cnt   <= 2'd2;
							state <= ST_HDR;
							if ({ver_byte, pay_data} == {VERSION_MAJOR, VERSION_MINOR}) begin
								resp_code <= RESP_ACK;
							end else begin
								// Mismatch also reports our own version
								resp_code   <= RESP_NAK;
								data_is_ver <= 1'b1;
								after_data  <= 1'b1;
							end
						end
					end
				end
				ST_QUERY_SUB: begin
					if (pay_valid) begin
						state <= ST_HDR;
						if (sub_sel != SEL_NONE) begin
							sel_q      <= sub_sel;
							cnt        <= sel_width(sub_sel);
							resp_code  <= RESP_ACK;
							after_data <= 1'b1;
						end else begin
							resp_code <= RESP_NAK;
						end
					end
				end
				ST_SET_SUB: begin
					if (pay_valid) begin
						if (sub_sel != SEL_NONE) begin
							sel_q <= sub_sel;
							cnt   <= sel_width(sub_sel);
							state <= ST_SET_DATA;
						end else begin
							resp_code <= RESP_NAK;
							state     <= ST_HDR;
						end
					end
				end
				ST_SET_DATA: begin
					if (pay_valid) begin
						cnt <= cnt - 2'd1;
						if (cnt == 2'd1) begin
							resp_code    <= RESP_ACK;
							after_commit <= sel_q inside {SEL_GPIO_LEVEL, SEL_GPIO_DIR, SEL_GPIO_INT};
							state        <= ST_HDR;
						end
					end
				end
				ST_HDR: begin
					if (!full) begin
						hdr_idx <= hdr_idx + 2'd1;
						if (hdr_idx == 2'd2) begin
							if (after_data) begin
								state <= ST_DATA;
							end else if (after_commit) begin
								state <= ST_DRAIN;
							end else begin
								state <= ST_IDLE;
							end
						end
					end
				end
				ST_DATA: begin
					if (!full) begin
						cnt <= cnt - 2'd1;
						if (cnt == 2'd1) begin
							state <= ST_IDLE;
						end
					end
				end
				// GPIO outputs change only once the ACK is fully out
				ST_DRAIN: begin
					if (empty && !tx_busy) begin
						state <= ST_COMMIT;
					end
				end
				ST_COMMIT: state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd_event_valid) begin
			cmd_q <= cmd_event.cmd;
			eid_q <= cmd_event.eid;
		end
		if (state == ST_VER && pay_valid && cnt == 2'd0) begin
			ver_byte <= pay_data;
		end
	end

	// GPIO commit only with the queue and the transmitter idle
	commit_after_drain: assert property (@(posedge clk) disable iff (rst)
		param_wr.commit |-> empty && !tx_busy);

endmodule

//--- cmd_frame_parser.sv
`timescale 1ns/10ps

module cmd_frame_parser (
	input  logic                   clk,
	input  logic                   rst,
	input  basics_pkg::in_bus_t    in_bus,
	input  logic                   nak_request,
	output basics_pkg::cmd_event_t cmd_event,
	output logic                   cmd_event_valid,
	output basics_pkg::byte_t      pay_data,
	output logic                   pay_valid
);
	import basics_pkg::*;

	logic       frame_q;
	logic       active;
	logic [1:0] hdr_cnt;
	logic       frame_start;
	logic       known_cmd;

	// First valid byte of a new frame is the command
	assign frame_start = in_bus.valid && in_bus.frame && !frame_q;

	always_comb begin
		case (in_bus.data)
			CMD_VERSION, CMD_QUERY_I2C, CMD_SET_I2C,
			CMD_QUERY_GPIO, CMD_SET_GPIO: known_cmd = 1'b1;
			default:                      known_cmd = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_q         <= 1'b0;
			active          <= 1'b0;
			hdr_cnt         <= 2'd0;
			cmd_event_valid <= 1'b0;
			pay_valid       <= 1'b0;
		end else begin
			frame_q         <= in_bus.frame;
			cmd_event_valid <= 1'b0;
			pay_valid       <= 1'b0;
			if (frame_start) begin
				// Unknown commands are dropped unless a NAK is forced
				active  <= known_cmd || nak_request;
				hdr_cnt <= 2'd1;
			end else if (!in_bus.frame) begin
				active <= 1'b0;
			end else if (active && in_bus.valid) begin
				case (hdr_cnt)
					2'd1: hdr_cnt <= 2'd2;
					2'd2: begin
						// Length byte, ignored
						hdr_cnt         <= 2'd3;
						cmd_event_valid <= 1'b1;
					end
					default: pay_valid <= 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start) begin
			cmd_event.cmd <= in_bus.data;
			cmd_event.nak <= nak_request;
		end
		if (active && in_bus.valid && hdr_cnt == 2'd1) begin
			cmd_event.eid <= in_bus.data;
		end
		if (in_bus.valid) begin
			pay_data <= in_bus.data;
		end
	end

	valid_inside_frame: assert property (@(posedge clk) disable iff (rst)
		$rose(in_bus.valid) |-> in_bus.frame);

endmodule

//--- credit_tx.sv
`timescale 1ns/10ps

module credit_tx #(
	parameter int CREDIT_INIT = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  basics_pkg::resp_byte_t head,
	input  logic                   empty,
	output logic                   pop,
	input  logic                   credit_return,
	output basics_pkg::resp_byte_t out_byte,
	output logic                   out_valid,
	output logic                   tx_busy
);
	import basics_pkg::*;

	localparam int CR_W = $clog2(CREDIT_INIT + 1);

	logic [CR_W-1:0] credits;

	// Send whenever something is queued and the receiver has room
	assign pop     = !empty && (credits != '0);
	assign tx_busy = out_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits   <= CR_W'(CREDIT_INIT);
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
			case ({pop, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_byte <= head;
		end
	end

	// Receiver never returns more than it was given
	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CR_W'(CREDIT_INIT));

endmodule

//--- param_bank.sv
`timescale 1ns/10ps

module param_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  basics_pkg::param_wr_t  param_wr,
	input  basics_pkg::gpio_word_t gpio_read,
	output basics_pkg::gpio_word_t rd_value,
	output basics_pkg::i2c_speed_t i2c_speed,
	output basics_pkg::i2c_addr_t  i2c_addr,
	output basics_pkg::gpio_word_t gpio_level,
	output basics_pkg::gpio_word_t gpio_direction,
	output basics_pkg::gpio_word_t gpio_int_enable
);
	import basics_pkg::*;

	// GPIO values collect here until the ACK has left
	gpio_word_t level_stage;
	gpio_word_t dir_stage;
	gpio_word_t int_stage;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			i2c_speed       <= I2C_SPEED_RESET;
			i2c_addr        <= I2C_ADDR_RESET;
			gpio_level      <= GPIO_RESET;
			gpio_direction  <= GPIO_RESET;
			gpio_int_enable <= GPIO_RESET;
		end else begin
			if (param_wr.shift) begin
				case (param_wr.sel)
					SEL_I2C_SPEED: i2c_speed <= param_wr.data;
					SEL_I2C_ADDR:  i2c_addr  <= {i2c_addr[7:0], param_wr.data};
					default: ;
				endcase
			end
			if (param_wr.commit) begin
				case (param_wr.sel)
					SEL_GPIO_LEVEL: gpio_level      <= level_stage;
					SEL_GPIO_DIR:   gpio_direction  <= dir_stage;
					SEL_GPIO_INT:   gpio_int_enable <= int_stage;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (param_wr.shift) begin
			case (param_wr.sel)
				SEL_GPIO_LEVEL: level_stage <= {level_stage[15:0], param_wr.data};
				SEL_GPIO_DIR:   dir_stage   <= {dir_stage[15:0], param_wr.data};
				SEL_GPIO_INT:   int_stage   <= {int_stage[15:0], param_wr.data};
				default: ;
			endcase
		end
	end

	// Read mux, right-aligned; level reads back the pins
	always_comb begin
		case (param_wr.sel)
			SEL_I2C_SPEED:  rd_value = {16'h0000, i2c_speed};
			SEL_I2C_ADDR:   rd_value = {8'h00, i2c_addr};
			SEL_GPIO_LEVEL: rd_value = gpio_read;
			SEL_GPIO_DIR:   rd_value = gpio_direction;
			SEL_GPIO_INT:   rd_value = gpio_int_enable;
			default:        rd_value = '0;
		endcase
	end

endmodule

//--- resp_fifo.sv
`timescale 1ns/10ps

module resp_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  basics_pkg::resp_byte_t push_data,
	input  logic                   pop,
	output basics_pkg::resp_byte_t head,
	output logic                   empty,
	output logic                   full
);
	import basics_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	resp_byte_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wraps for depths that are not a power of two too
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty);

endmodule

//--- tb_basics.sv
`timescale 1ns/10ps

module tb_basics;
	import basics_pkg::*;

	localparam byte_t VER_MAJOR = 8'h00;
	localparam byte_t VER_MINOR = 8'h03;
	localparam int    DEPTH     = 16;
	localparam int    CREDITS   = 4;
	localparam int    TIMEOUT   = 400;

	logic        clk;
	logic        rst;
	in_bus_t     in_bus;
	logic        nak_request;
	logic        credit_return;
	resp_byte_t  out_byte;
	logic        out_valid;
	gpio_word_t  gpio_read;
	i2c_speed_t  i2c_speed;
	i2c_addr_t   i2c_addr;
	gpio_word_t  gpio_level;
	gpio_word_t  gpio_direction;
	gpio_word_t  gpio_int_enable;
	logic        coin;
	logic        hold_credits;
	int unsigned lcg_state = 2;
	byte_t       pl [4];
	int          base;
	int          n;

	basics_top #(
		.VERSION_MAJOR (VER_MAJOR),
		.VERSION_MINOR (VER_MINOR),
		.FIFO_DEPTH    (DEPTH),
		.CREDIT_INIT   (CREDITS)
	) i_dut (
		.clk             (clk),
		.rst             (rst),
		.in_bus          (in_bus),
		.nak_request     (nak_request),
		.credit_return   (credit_return),
		.out_byte        (out_byte),
		.out_valid       (out_valid),
		.gpio_read       (gpio_read),
		.i2c_speed       (i2c_speed),
		.i2c_addr        (i2c_addr),
		.gpio_level      (gpio_level),
		.gpio_direction  (gpio_direction),
		.gpio_int_enable (gpio_int_enable)
	);

	tb_checker #(
		.VERSION_MAJOR (VER_MAJOR),
		.VERSION_MINOR (VER_MINOR),
		.CREDIT_INIT   (CREDITS)
	) i_checker (
		.clk             (clk),
		.rst             (rst),
		.out_byte        (out_byte),
		.out_valid       (out_valid),
		.coin            (coin),
		.hold_credits    (hold_credits),
		.gpio_read       (gpio_read),
		.i2c_speed       (i2c_speed),
		.i2c_addr        (i2c_addr),
		.gpio_level      (gpio_level),
		.gpio_direction  (gpio_direction),
		.gpio_int_enable (gpio_int_enable),
		.credit_return   (credit_return)
	);

	function int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) coin <= lcg_next() % 3 != 0;

	// One frame: command, EID, length, then len payload bytes
	task automatic send_frame(input byte_t cmd, input int len, input byte_t p [4],
			input logic wait_resp);
		byte_t eid;
		eid = byte_t'(lcg_next());
		i_checker.build_expected(cmd, eid, nak_request, p);
		for (int i = 0; i < len + 3; i++) begin
			@(negedge clk);
			in_bus.frame = 1'b1;
			in_bus.valid = 1'b1;
			in_bus.data = (i == 0) ? cmd : (i == 1) ? eid : (i == 2) ? byte_t'(len) : p[i-3];
		end
		@(negedge clk);
		in_bus = '0;
		if (wait_resp) begin
			i_checker.wait_drained(TIMEOUT);
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic fill_random();
		for (int i = 0; i < 4; i++) begin
			pl[i] = byte_t'(lcg_next());
		end
	endtask

	initial begin
		rst = 1'b1;
		in_bus = '0;
		nak_request = 1'b0;
		hold_credits = 1'b0;
		coin = 1'b0;
		gpio_read = gpio_word_t'(lcg_next());
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);

		// Version match and mismatch
		pl = '{VER_MAJOR, VER_MINOR, 8'h00, 8'h00};
		send_frame(CMD_VERSION, 2, pl, 1'b1);
		fill_random();
		if (pl[0] == VER_MAJOR && pl[1] == VER_MINOR) begin
			pl[1] = pl[1] ^ 8'h80;
		end
		send_frame(CMD_VERSION, 2, pl, 1'b1);

		// I2C settings
		pl[0] = SUB_I2C_SPEED;
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);
		pl[0] = SUB_I2C_ADDR;
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);
		fill_random();
		pl[0] = SUB_I2C_SPEED;
		send_frame(CMD_SET_I2C, 2, pl, 1'b1);
		fill_random();
		pl[0] = SUB_I2C_ADDR;
		send_frame(CMD_SET_I2C, 3, pl, 1'b1);
		i_checker.check_outputs(TIMEOUT);
		pl[0] = SUB_I2C_SPEED;
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);
		pl[0] = SUB_I2C_ADDR;
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);

		// GPIO settings and readback
		foreach (pl[i]) begin
			fill_random();
			pl[0] = (i == 0) ? SUB_GPIO_DIR : (i == 1) ? SUB_GPIO_INT : SUB_GPIO_LEVEL;
			if (i < 3) begin
				send_frame(CMD_SET_GPIO, 4, pl, 1'b1);
				i_checker.check_outputs(TIMEOUT);
			end
		end
		foreach (pl[i]) begin
			pl[0] = (i == 0) ? SUB_GPIO_DIR : (i == 1) ? SUB_GPIO_INT : SUB_GPIO_LEVEL;
			if (i < 3) begin
				send_frame(CMD_QUERY_GPIO, 1, pl, 1'b1);
			end
		end

		// Forced NAK and unknown sub bytes
		nak_request = 1'b1;
		pl[0] = SUB_I2C_SPEED;
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);
		nak_request = 1'b0;
		pl = '{8'h7A, 8'h12, 8'h34, 8'h56};
		send_frame(CMD_QUERY_I2C, 1, pl, 1'b1);
		send_frame(CMD_SET_GPIO, 4, pl, 1'b1);
		i_checker.check_outputs(TIMEOUT);

		// Unknown command, then a normal one
		send_frame(8'h55, 2, pl, 1'b1);
		repeat (20) @(negedge clk);
		pl = '{VER_MAJOR, VER_MINOR, 8'h00, 8'h00};
		send_frame(CMD_VERSION, 2, pl, 1'b1);

		// Credits withheld for a six-byte response
		n = 0;
		while (n < TIMEOUT && i_checker.owed != 0) begin
			@(negedge clk);
			n++;
		end
		if (i_checker.owed != 0) begin
			i_checker.other_errors++;
			$display("Credits were not returned before the flow control test");
		end
		hold_credits = 1'b1;
		base = i_checker.rx_count;
		pl[0] = SUB_GPIO_DIR;
		send_frame(CMD_QUERY_GPIO, 1, pl, 1'b0);
		n = 0;
		while (n < TIMEOUT && i_checker.rx_count - base < CREDITS) begin
			@(negedge clk);
			n++;
		end
		repeat (30) @(negedge clk);
		if (i_checker.rx_count - base != CREDITS) begin
			i_checker.other_errors++;
			$display("Sent %0d bytes with credits withheld, allowed %0d",
				i_checker.rx_count - base, CREDITS);
		end
		hold_credits = 1'b0;
		i_checker.wait_drained(TIMEOUT);
		repeat (5) @(negedge clk);

		$display("Errors: %0d value, %0d other",
			i_checker.value_errors, i_checker.other_errors);
		if (i_checker.value_errors == 0 && i_checker.other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Run limit
	initial begin
		#2ms;
		$display("Simulation ran past its time limit");
		$display("Test failed");
		$finish;
	end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
	parameter basics_pkg::byte_t VERSION_MAJOR = 8'h00,
	parameter basics_pkg::byte_t VERSION_MINOR = 8'h03,
	parameter int                CREDIT_INIT   = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  basics_pkg::resp_byte_t out_byte,
	input  logic                   out_valid,
	input  logic                   coin,
	input  logic                   hold_credits,
	input  basics_pkg::gpio_word_t gpio_read,
	input  basics_pkg::i2c_speed_t i2c_speed,
	input  basics_pkg::i2c_addr_t  i2c_addr,
	input  basics_pkg::gpio_word_t gpio_level,
	input  basics_pkg::gpio_word_t gpio_direction,
	input  basics_pkg::gpio_word_t gpio_int_enable,
	output logic                   credit_return
);
	import basics_pkg::*;

	byte_t      exp_data [$];
	logic       exp_last [$];
	int         owed = 0;
	int         rx_count = 0;
	int         value_errors = 0;
	int         other_errors = 0;
	i2c_speed_t m_speed = I2C_SPEED_RESET;
	i2c_addr_t  m_addr = I2C_ADDR_RESET;
	gpio_word_t m_level = '0;
	gpio_word_t m_dir = '0;
	gpio_word_t m_int = '0;

	initial credit_return = 1'b0;

	function void add_byte(input byte_t b, input logic last);
		exp_data.push_back(b);
		exp_last.push_back(last);
	endfunction

	function void add_frame(input byte_t code, input byte_t eid);
		add_byte(code, 1'b0);
		add_byte(eid, 1'b0);
		add_byte(8'h00, 1'b1);
	endfunction

	// Expected response bytes and register model update
	function void build_expected(input byte_t cmd, input byte_t eid, input logic nak,
			input byte_t pl [4]);
		gpio_word_t val;
		int         w;
		val = '0;
		w = 0;
		if (nak) begin
			add_frame(RESP_NAK, eid);
		end else if (cmd == CMD_VERSION) begin
			if (pl[0] == VERSION_MAJOR && pl[1] == VERSION_MINOR) begin
				add_frame(RESP_ACK, eid);
			end else begin
				add_frame(RESP_NAK, eid);
				add_byte(VERSION_MAJOR, 1'b0);
				add_byte(VERSION_MINOR, 1'b1);
			end
		end else if (cmd == CMD_QUERY_I2C || cmd == CMD_QUERY_GPIO) begin
			if (cmd == CMD_QUERY_I2C && pl[0] == SUB_I2C_SPEED) begin
				val = {16'h0, m_speed};
				w = 1;
			end else if (cmd == CMD_QUERY_I2C && pl[0] == SUB_I2C_ADDR) begin
				val = {8'h0, m_addr};
				w = 2;
			end else if (cmd == CMD_QUERY_GPIO && pl[0] == SUB_GPIO_LEVEL) begin
				val = gpio_read;
				w = 3;
			end else if (cmd == CMD_QUERY_GPIO && pl[0] == SUB_GPIO_DIR) begin
				val = m_dir;
				w = 3;
			end else if (cmd == CMD_QUERY_GPIO && pl[0] == SUB_GPIO_INT) begin
				val = m_int;
				w = 3;
			end
			if (w == 0) begin
				add_frame(RESP_NAK, eid);
			end else begin
				add_frame(RESP_ACK, eid);
				for (int i = w - 1; i >= 0; i--) begin
					add_byte(val[8*i +: 8], i == 0);
				end
			end
		end else if (cmd == CMD_SET_I2C || cmd == CMD_SET_GPIO) begin
			w = 1;
			if (cmd == CMD_SET_I2C && pl[0] == SUB_I2C_SPEED) begin
				m_speed = pl[1];
			end else if (cmd == CMD_SET_I2C && pl[0] == SUB_I2C_ADDR) begin
				m_addr = {pl[1], pl[2]};
			end else if (cmd == CMD_SET_GPIO && pl[0] == SUB_GPIO_LEVEL) begin
				m_level = {pl[1], pl[2], pl[3]};
			end else if (cmd == CMD_SET_GPIO && pl[0] == SUB_GPIO_DIR) begin
				m_dir = {pl[1], pl[2], pl[3]};
			end else if (cmd == CMD_SET_GPIO && pl[0] == SUB_GPIO_INT) begin
				m_int = {pl[1], pl[2], pl[3]};
			end else begin
				w = 0;
			end
			add_frame(w != 0 ? RESP_ACK : RESP_NAK, eid);
		end
		// Unknown commands expect nothing
	endfunction

	function logic outputs_match();
		return i2c_speed == m_speed && i2c_addr == m_addr && gpio_level == m_level
			&& gpio_direction == m_dir && gpio_int_enable == m_int;
	endfunction

	task automatic check_value(input string name, input gpio_word_t got, input gpio_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s expected %h got %h", name, exp, got);
		end
	endtask

	// Waits for pending GPIO commits, then compares every register output
	task automatic check_outputs(input int timeout);
		int n;
		n = 0;
		while (n < timeout && !outputs_match()) begin
			@(negedge clk);
			n++;
		end
		check_value("i2c_speed", {16'h0, i2c_speed}, {16'h0, m_speed});
		check_value("i2c_addr", {8'h0, i2c_addr}, {8'h0, m_addr});
		check_value("gpio_level", gpio_level, m_level);
		check_value("gpio_direction", gpio_direction, m_dir);
		check_value("gpio_int_enable", gpio_int_enable, m_int);
	endtask

	task automatic wait_drained(input int timeout);
		int n;
		n = 0;
		while (n < timeout && exp_data.size() != 0) begin
			@(negedge clk);
			n++;
		end
		if (exp_data.size() != 0) begin
			other_errors++;
			$display("Timed out waiting for %0d response bytes", exp_data.size());
		end
	endtask

	// Received bytes are compared in order and credits go back at random
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			rx_count++;
			owed++;
			if (owed > CREDIT_INIT) begin
				other_errors++;
				$display("More than %0d bytes were sent without a returned credit",
					CREDIT_INIT);
			end
			if (exp_data.size() == 0) begin
				other_errors++;
				$display("Output byte %h arrived with no response expected", out_byte.data);
			end else begin
				if (out_byte.data !== exp_data[0]) begin
					value_errors++;
					$display("Error: out_byte.data expected %h got %h",
						exp_data[0], out_byte.data);
				end
				if (out_byte.last !== exp_last[0]) begin
					value_errors++;
					$display("Error: out_byte.last expected %h got %h",
						exp_last[0], out_byte.last);
				end
				void'(exp_data.pop_front());
				void'(exp_last.pop_front());
			end
		end
		if (!rst && !hold_credits && owed > 0 && coin) begin
			credit_return = 1'b1;
			owed--;
		end else begin
			credit_return = 1'b0;
		end
	end

endmodule

//--- vlog.f
basics_pkg.sv
cmd_frame_parser.sv
cmd_controller.sv
param_bank.sv
resp_fifo.sv
credit_tx.sv
basics_top.sv
tb_checker.sv
tb_basics.sv
